// File: bench/yuv420_assertions.sv
`timescale 1ns/1ps

module yuv420_assertions #(
   parameter int QDEPTH = 8,
   parameter int QW     = 4
) (
   input logic          clk,
   input logic          resetb,
   input logic          out_valid,
   input logic          out_credit,
   input logic [QW-1:0] q_count,
   input logic          in_credit,
   input logic          beat_in
);

   logic [15:0] beats_rx;    // Aligned beats seen by the packer
   logic [15:0] creds_tx;    // in_credit pulses already returned
   logic [15:0] grants_rx;   // out_credit pulses granted by the sink
   logic [15:0] items_tx;    // Items already sent on the output

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beats_rx  <= '0;
         creds_tx  <= '0;
         grants_rx <= '0;
         items_tx  <= '0;
      end else begin
         if (beat_in) beats_rx <= beats_rx + 16'd1;
         if (in_credit) creds_tx <= creds_tx + 16'd1;
         if (out_credit) grants_rx <= grants_rx + 16'd1;
         if (out_valid) items_tx <= items_tx + 16'd1;
      end
   end

   // Every item on the output spends a credit granted earlier
   out_needs_credit: assert property (@(posedge clk) disable iff (!resetb)
      out_valid |-> (items_tx < grants_rx))
      else $error("out_valid without an output credit");

   queue_bound: assert property (@(posedge clk) disable iff (!resetb)
      q_count <= QW'(QDEPTH))
      else $error("output queue overflow");

   credit_bound: assert property (@(posedge clk) disable iff (!resetb)
      in_credit |-> (creds_tx < beats_rx))
      else $error("in_credit returned for a beat never received");

endmodule

bind stream_packer yuv420_assertions #(
   .QDEPTH (QDEPTH),
   .QW     (QAW + 1)
) u_assertions (
   .clk        (clk),
   .resetb     (resetb),
   .out_valid  (out_valid),
   .out_credit (out_credit),
   .q_count    (q_count),
   .in_credit  (in_credit),
   .beat_in    (nx_valid | nx_nocred)
);

// File: bench/yuv420_tb.sv
`timescale 1ns/1ps

module yuv420_tb;
   import stream_pkg::*;
   import pixel_pkg::*;

   localparam int INPUT_CREDITS = 4;
   localparam int MAX_COLS      = 64;
   localparam int TOTAL_BEATS   = 42 + 34 + 7 + 7 + 42;   // All five tests together
   localparam int CYCLE_LIMIT   = 40 * TOTAL_BEATS;

   logic clk, resetb, yuv_en, yuv420_en, in_valid, out_credit;
   logic in_credit, out_valid;
   dtype_e in_dtype, out_dtype;
   logic [15:0] in_meta;
   pix_t in_y, in_u, in_v;
   logic [31:0] out_data;

   dtype_e      s_dt[$];   // Stimulus of the current test
   pix_t        s_y[$];
   pix_t        s_u[$];
   pix_t        s_v[$];
   logic [15:0] s_meta[$];
   dtype_e      exp_dt[$];
   logic [31:0] exp_data[$];
   pix_t        cu[0:7][0:MAX_COLS-1];
   pix_t        cv[0:7][0:MAX_COLS-1];

   int errors = 0;
   int n_items = 0;
   int beats_sent = 0;
   int credits_back = 0;
   int cycles = 0;
   int grant_mod = 2;   // out_credit is granted on one cycle in grant_mod

   yuv420_top #(.INPUT_CREDITS(INPUT_CREDITS), .MAX_COLS(MAX_COLS)) dut (
      .clk(clk), .resetb(resetb), .yuv_en(yuv_en), .yuv420_en(yuv420_en),
      .in_valid(in_valid), .in_dtype(in_dtype), .in_meta(in_meta),
      .in_y(in_y), .in_u(in_u), .in_v(in_v), .in_credit(in_credit),
      .out_valid(out_valid), .out_dtype(out_dtype), .out_data(out_data),
      .out_credit(out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Floor of the signed 2x2 mean, then the optional offset
   function automatic pix_t ref_avg(input pix_t a, input pix_t b, input pix_t c,
                                    input pix_t d, input bit offs);
      int s;
      s = int'($signed(a)) + int'($signed(b)) + int'($signed(c)) + int'($signed(d));
      s = s >>> 2;
      return pix_t'(s) + (offs ? 8'd128 : 8'd0);
   endfunction

   function automatic void add_item(input dtype_e dt, input logic [31:0] d);
      exp_dt.push_back(dt);
      exp_data.push_back(d);
   endfunction

   // Reference model of the whole stream for the stimulus now queued
   function automatic void expect_beats(input bit mode420, input bit offs);
      pix_t        bq[$];
      int          row;
      int          col;
      bit          hsecond;
      logic [15:0] hlo;
      pix_t        off;
      row = 0;
      col = 0;
      hsecond = 1'b0;
      hlo = '0;
      off = offs ? 8'd128 : 8'd0;
      foreach (s_dt[i]) begin
         case (s_dt[i])
            FRAME_START: begin
               row = 0;
               bq.delete();
               add_item(FRAME_START, 32'h0);
            end
            ROW_START: begin
               col = 0;
               add_item(ROW_START, 32'h0);
            end
            ROW_END: begin
               row++;
               add_item(ROW_END, 32'h0);
            end
            PIXEL: begin
               cu[row][col] = s_u[i];
               cv[row][col] = s_v[i];
               bq.push_back(s_y[i]);
               if (!mode420) begin
                  bq.push_back(s_u[i] + off);
                  bq.push_back(s_v[i] + off);
               end else if (row % 2 == 1 && col % 2 == 1) begin
                  bq.push_back(ref_avg(cu[row-1][col-1], cu[row-1][col],
                                       cu[row][col-1], cu[row][col], offs));
                  bq.push_back(ref_avg(cv[row-1][col-1], cv[row-1][col],
                                       cv[row][col-1], cv[row][col], offs));
               end
               col++;
               while (bq.size() >= 4) begin
                  add_item(PIXEL, {bq[3], bq[2], bq[1], bq[0]});
                  repeat (4) void'(bq.pop_front());
               end
            end
            HEADER_START: begin
               hsecond = 1'b0;
               add_item(HEADER_START, 32'h0);
            end
            HEADER: begin
               if (hsecond) add_item(HEADER, {s_meta[i], hlo});   // Earlier value low
               else hlo = s_meta[i];
               hsecond = !hsecond;
            end
            FRAME_END: begin
               if (bq.size() > 0) begin
                  while (bq.size() < 4) bq.push_back(8'h00);
                  add_item(PIXEL, {bq[3], bq[2], bq[1], bq[0]});
                  bq.delete();
               end
               add_item(FRAME_END, 32'h0);
            end
            default: add_item(s_dt[i], 32'h0);
         endcase
      end
   endfunction

   task automatic add_beat(input dtype_e dt, input pix_t y, input pix_t u, input pix_t v,
                           input logic [15:0] m);
      s_dt.push_back(dt);
      s_y.push_back(y);
      s_u.push_back(u);
      s_v.push_back(v);
      s_meta.push_back(m);
   endtask

   task automatic clear_stim();
      s_dt.delete();
      s_y.delete();
      s_u.delete();
      s_v.delete();
      s_meta.delete();
   endtask

   task automatic build_frame(input int cols, input int rows);
      add_beat(FRAME_START, 8'h0, 8'h0, 8'h0, 16'h0);
      for (int r = 0; r < rows; r++) begin
         add_beat(ROW_START, 8'h0, 8'h0, 8'h0, 16'h0);
         for (int c = 0; c < cols; c++) begin
            add_beat(PIXEL, 8'($urandom), 8'($urandom), 8'($urandom), 16'h0);
         end
         add_beat(ROW_END, 8'h0, 8'h0, 8'h0, 16'h0);
      end
      add_beat(FRAME_END, 8'h0, 8'h0, 8'h0, 16'h0);
   endtask

   task automatic build_header(input int n);
      add_beat(HEADER_START, 8'h0, 8'h0, 8'h0, 16'h0);
      repeat (n) add_beat(HEADER, 8'h0, 8'h0, 8'h0, 16'($urandom));
   endtask

   // Sends the queued beats, one per held credit, then waits for the queue to drain
   task automatic run_stim(input bit mode420, input bit offs);
      int i;
      @(negedge clk);
      yuv420_en = mode420;
      yuv_en    = offs;
      expect_beats(mode420, offs);
      i = 0;
      while (i < s_dt.size()) begin
         @(negedge clk);
         if (beats_sent - credits_back < INPUT_CREDITS) begin
            in_valid = 1'b1;
            in_dtype = s_dt[i];
            in_y     = s_y[i];
            in_u     = s_u[i];
            in_v     = s_v[i];
            in_meta  = s_meta[i];
            beats_sent++;
            i++;
         end else begin
            in_valid = 1'b0;
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
      while (credits_back < beats_sent || exp_dt.size() != 0) @(negedge clk);
      clear_stim();
   endtask

   always @(negedge clk) begin
      if (resetb && in_credit) credits_back++;
      out_credit = resetb && ($urandom % grant_mod == 0);
   end

   // Compare each output item with the head of the expected list
   always @(negedge clk) begin
      if (resetb && out_valid) begin
         n_items++;
         if (exp_dt.size() == 0) begin
            $display("Unexpected output item at %0t with no item expected", $time);
            errors++;
         end else begin
            if (out_dtype != exp_dt[0]) begin
               $display("MISMATCH %0t out_dtype expected %0h actual %0h",
                        $time, exp_dt[0], out_dtype);
               errors++;
            end
            if (out_data != exp_data[0]) begin
               $display("MISMATCH %0t out_data expected %08h actual %08h",
                        $time, exp_data[0], out_data);
               errors++;
            end
            void'(exp_dt.pop_front());
            void'(exp_data.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles with %0d items still expected",
                  cycles, exp_dt.size());
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h66f0));
      resetb     = 1'b0;
      yuv_en     = 1'b0;
      yuv420_en  = 1'b0;
      in_valid   = 1'b0;
      in_dtype   = FRAME_START;
      in_meta    = 16'h0;
      in_y       = 8'h0;
      in_u       = 8'h0;
      in_v       = 8'h0;
      out_credit = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;

      build_frame(8, 4);   // 4:4:4 with offset
      run_stim(1'b0, 1'b1);
      build_frame(6, 4);   // 4:2:0 with random chroma
      run_stim(1'b1, 1'b1);
      build_frame(3, 1);   // Nine bytes leave a partial word at frame end
      run_stim(1'b0, 1'b0);
      build_header(6);
      run_stim(1'b0, 1'b0);
      grant_mod = 8;       // Sparse output credit
      build_frame(8, 4);
      run_stim(1'b0, 1'b1);
      repeat (4) @(negedge clk);   // Idle cycles so a stray in_credit pulse is still counted

      if (credits_back != beats_sent) begin
         $display("in_credit pulses %0d do not match beats sent %0d", credits_back, beats_sent);
         errors++;
      end
      $display("Checked %0d items over %0d beats, %0d errors", n_items, beats_sent, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
src/stream_pkg.sv
src/pixel_pkg.sv
src/pixel_beat_if.sv
src/luma_align.sv
src/chroma_subsample.sv
src/stream_packer.sv
src/yuv420_top.sv
bench/yuv420_assertions.sv
bench/yuv420_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module yuv420_tb -o yuv420_sim \
   && ./obj_dir/yuv420_sim | grep "Simulation completed successfully" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// File: src/chroma_subsample.sv
`timescale 1ns/1ps

module chroma_subsample #(
   parameter int MAX_COLS = 64
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               yuv_en,
   input  logic               in_valid,
   input  stream_pkg::dtype_e in_dtype,
   input  pixel_pkg::pix_t    in_u,
   input  pixel_pkg::pix_t    in_v,
   output pixel_pkg::pix_t    avg_u,
   output pixel_pkg::pix_t    avg_v,
   output logic               dump
);
   import stream_pkg::*;
   import pixel_pkg::*;

   localparam int CW = $clog2(MAX_COLS);

   logic          row_phase;   // High on odd rows of the frame
   logic [CW-1:0] col_cnt;     // Column of the pixel now on the input
   logic          col_phase;
   logic [CW-1:0] col_even;    // Left neighbour of an odd column
   logic          is_pixel;
   logic          take;

   // Chroma of the even row above, one entry per column
   pix_t line_u [MAX_COLS];
   pix_t line_v [MAX_COLS];
   pix_t prev_u;   // Previous column on the current row
   pix_t prev_v;

   // Floor of the mean of four signed values, then the optional offset
   function automatic pix_t avg4(input pix_t a, input pix_t b, input pix_t c,
                                 input pix_t d, input logic offs);
      logic signed [9:0] sum;
      logic signed [9:0] mean;
      sum = $signed({{2{a[7]}}, a}) + $signed({{2{b[7]}}, b})
          + $signed({{2{c[7]}}, c}) + $signed({{2{d[7]}}, d});
      mean = sum >>> 2;   // Arithmetic shift rounds toward minus infinity
      return offs ? mean[7:0] + CHROMA_OFFSET : mean[7:0];
   endfunction

   assign is_pixel  = in_valid && (in_dtype == PIXEL);
   assign col_phase = col_cnt[0];
   assign col_even  = col_cnt ^ CW'(1);
   assign take      = is_pixel && row_phase && col_phase;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_phase <= 1'b0;
         col_cnt   <= '0;
      end else if (in_valid) begin
         case (in_dtype)
            FRAME_START: row_phase <= 1'b0;
            ROW_END:     row_phase <= ~row_phase;
            ROW_START:   col_cnt   <= '0;
            PIXEL:       col_cnt   <= col_cnt + 1'b1;
            default:     ;
         endcase
      end
   end

   // The line buffer is filled on even rows and read back on the odd row below
   always_ff @(posedge clk) begin
      if (is_pixel) begin
         prev_u <= in_u;
         prev_v <= in_v;
         if (!row_phase) begin
            line_u[col_cnt] <= in_u;
            line_v[col_cnt] <= in_v;
         end
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dump <= 1'b0;
      end else begin
         dump <= take;   // Same cycle as the aligned beat
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         avg_u <= avg4(line_u[col_even], line_u[col_cnt], prev_u, in_u, yuv_en);
         avg_v <= avg4(line_v[col_even], line_v[col_cnt], prev_v, in_v, yuv_en);
      end
   end

endmodule

// File: src/luma_align.sv
`timescale 1ns/1ps

module luma_align (
   input  logic               clk,
   input  logic               resetb,
   input  logic               yuv_en,
   input  logic               in_valid,
   input  stream_pkg::dtype_e in_dtype,
   input  pixel_pkg::pix_t    in_y,
   input  pixel_pkg::pix_t    in_u,
   input  pixel_pkg::pix_t    in_v,
   input  logic [15:0]        in_meta,
   pixel_beat_if.sender       beat
);
   import pixel_pkg::*;

   pix_t u_off;
   pix_t v_off;

   // Chroma offset wraps around on overflow, as YUV wants
   assign u_off = yuv_en ? in_u + CHROMA_OFFSET : in_u;
   assign v_off = yuv_en ? in_v + CHROMA_OFFSET : in_v;

   // One register stage, matching the latency of the chroma subsampler
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat.valid <= 1'b0;
      end else begin
         beat.valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      beat.dtype <= in_dtype;
      beat.y     <= in_y;
      beat.u     <= u_off;
      beat.v     <= v_off;
      beat.meta  <= in_meta;   // Header payload rides along unchanged
   end

endmodule

// File: src/pixel_beat_if.sv
`timescale 1ns/1ps

interface pixel_beat_if;
   import stream_pkg::*;
   import pixel_pkg::*;

   logic        valid;
   dtype_e      dtype;
   pix_t        y;
   pix_t        u;   // Already offset in 4:4:4 use when yuv_en is set
   pix_t        v;
   logic [15:0] meta;

   modport sender (
      output valid, dtype, y, u, v, meta
   );

   modport receiver (
      input valid, dtype, y, u, v, meta
   );

endinterface

// File: src/pixel_pkg.sv
package pixel_pkg;

   // One channel byte
   typedef logic [7:0] pix_t;

   // Added to chroma to move it from signed to offset-binary form
   localparam pix_t CHROMA_OFFSET = 8'd128;

   // One output word, read either as four pixel bytes or as two header halves
   // Byte 0 and half 0 sit in the low bits and are the first on the stream
   typedef union packed {
      pix_t [3:0]       bytes;
      logic [1:0][15:0] halves;
   } out_word_u;

endpackage

// File: src/stream_packer.sv
`timescale 1ns/1ps

module stream_packer #(
   parameter int INPUT_CREDITS = 4
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               yuv420_en,
   pixel_beat_if.receiver     beat,
   input  pixel_pkg::pix_t    avg_u,
   input  pixel_pkg::pix_t    avg_v,
   input  logic               dump,
   output logic               in_credit,
   output logic               out_valid,
   output stream_pkg::dtype_e out_dtype,
   output logic [31:0]        out_data,
   input  logic               out_credit
);
   import stream_pkg::*;
   import pixel_pkg::*;

   localparam int QDEPTH = 2 * INPUT_CREDITS;   // Two items per outstanding beat
   localparam int QAW    = $clog2(QDEPTH);
   localparam int CRED_W = 8;
   localparam stream_item_t FE_ITEM = '{last: 1'b1, dtype: FRAME_END, data: 32'h0};

   logic [55:0]   bbuf;   // Pending bytes, oldest in the low bits
   logic [2:0]    bcnt;
   logic          hidx;   // Set once the lower header half is held
   logic [15:0]   meta_lo;
   logic [55:0]   bbuf_n;
   logic [2:0]    bcnt_n;
   logic          hidx_n;
   logic          nx_valid;
   logic          nx_flush;
   logic          nx_nocred;   // Beat that produces no item
   stream_item_t  nx_item;
   logic          st_valid;
   logic          st_flush;
   logic          fe_hold;     // FRAME_END item that follows a flush word
   stream_item_t  st_item;
   stream_item_t  q_mem [QDEPTH];
   logic [QAW-1:0] wptr;
   logic [QAW-1:0] wptr_p1;
   logic [QAW-1:0] rptr;
   logic [QAW:0]   q_count;
   logic [1:0]     nwr;
   logic           pop;
   logic [CRED_W-1:0] out_cred;

   function automatic logic [QAW-1:0] qinc(input logic [QAW-1:0] p);
      return (p == QAW'(QDEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_comb begin
      logic [23:0] new_bytes;
      logic [2:0]  nbytes;
      logic [55:0] merged;
      logic [2:0]  total;
      out_word_u   pw;
      out_word_u   hw;

      bbuf_n    = bbuf;
      bcnt_n    = bcnt;
      hidx_n    = hidx;
      nx_valid  = 1'b0;
      nx_flush  = 1'b0;
      nx_nocred = 1'b0;
      nx_item   = '0;

      new_bytes = {beat.v, beat.u, beat.y};   // 4:4:4 sends all three channels
      nbytes    = 3'd3;
      if (yuv420_en) begin
         new_bytes = dump ? {avg_v, avg_u, beat.y} : {16'h0, beat.y};
         nbytes    = dump ? 3'd3 : 3'd1;
      end
      merged    = bbuf | (56'(new_bytes) << {bcnt, 3'b000});
      total     = bcnt + nbytes;
      pw.bytes  = merged[31:0];
      hw.halves[0] = meta_lo;     // Earlier header value goes low
      hw.halves[1] = beat.meta;

      if (beat.valid) begin
         case (beat.dtype)
            PIXEL: begin
               if (total >= 3'd4) begin
                  nx_valid      = 1'b1;
                  nx_item.last  = 1'b1;
                  nx_item.dtype = PIXEL;
                  nx_item.data  = pw;
                  bbuf_n        = merged >> 32;
                  bcnt_n        = total - 3'd4;
               end else begin
                  nx_nocred = 1'b1;
                  bbuf_n    = merged;
                  bcnt_n    = total;
               end
            end
            HEADER: begin
               hidx_n = ~hidx;
               if (hidx) begin
                  nx_valid      = 1'b1;
                  nx_item.last  = 1'b1;
                  nx_item.dtype = HEADER;
                  nx_item.data  = hw;
               end else begin
                  nx_nocred = 1'b1;
               end
            end
            FRAME_END: begin
               nx_valid = 1'b1;
               bbuf_n   = '0;
               bcnt_n   = '0;
               if (bcnt != 3'd0) begin   // Zero-padded word goes out ahead of the marker
                  nx_flush      = 1'b1;
                  nx_item.dtype = PIXEL;
                  nx_item.data  = bbuf[31:0];
               end else begin
                  nx_item = FE_ITEM;
               end
            end
            default: begin
               nx_valid      = 1'b1;
               nx_item.last  = 1'b1;
               nx_item.dtype = beat.dtype;
               if (beat.dtype == HEADER_START) hidx_n = 1'b0;
               if (beat.dtype == FRAME_START) begin
                  bbuf_n = '0;
                  bcnt_n = '0;
               end
            end
         endcase
      end
   end

   // Hold back a last-item pop while a no-item beat returns its credit
   assign pop     = (q_count != '0) && (out_cred != '0) && !(q_mem[rptr].last && nx_nocred);
   assign nwr     = {1'b0, fe_hold} + {1'b0, st_valid};
   assign wptr_p1 = qinc(wptr);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         bbuf      <= '0;
         bcnt      <= '0;
         hidx      <= 1'b0;
         st_valid  <= 1'b0;
         st_flush  <= 1'b0;
         fe_hold   <= 1'b0;
         wptr      <= '0;
         rptr      <= '0;
         q_count   <= '0;
         out_cred  <= '0;
         out_valid <= 1'b0;
         in_credit <= 1'b0;
      end else begin
         bbuf      <= bbuf_n;
         bcnt      <= bcnt_n;
         hidx      <= hidx_n;
         st_valid  <= nx_valid;
         st_flush  <= nx_flush;
         fe_hold   <= st_flush;
         if (nwr == 2'd1) wptr <= wptr_p1;
         else if (nwr == 2'd2) wptr <= qinc(wptr_p1);
         if (pop) rptr <= qinc(rptr);
         q_count   <= q_count + (QAW+1)'(nwr) - (QAW+1)'(pop);
         out_cred  <= out_cred + CRED_W'(out_credit) - CRED_W'(pop);
         out_valid <= pop;
         in_credit <= nx_nocred | (pop & q_mem[rptr].last);
      end
   end

   always_ff @(posedge clk) begin
      if (beat.valid && beat.dtype == HEADER && !hidx) meta_lo <= beat.meta;
      st_item <= nx_item;
      // The held FRAME_END belongs to an older beat, so it is written first
      if (fe_hold) q_mem[wptr] <= FE_ITEM;
      if (st_valid) q_mem[fe_hold ? wptr_p1 : wptr] <= st_item;
      if (pop) begin
         out_dtype <= q_mem[rptr].dtype;
         out_data  <= q_mem[rptr].data;
      end
   end

endmodule

// File: src/stream_pkg.sv
package stream_pkg;

   // Width of the item type field on every stream
   localparam int DTYPE_W = 4;

   // Codes that travel with each beat and each output item
   typedef enum logic [DTYPE_W-1:0] {
      FRAME_START  = 4'h0,
      FRAME_END    = 4'h1,
      ROW_START    = 4'h2,
      ROW_END      = 4'h3,
      PIXEL        = 4'h4,
      HEADER_START = 4'h8,
      HEADER       = 4'h9
   } dtype_e;

   // One entry of the output queue
   // The last flag is set on the final item that a single input beat produces,
   // so its pop can hand the input credit back
   typedef struct packed {
      logic        last;
      dtype_e      dtype;
      logic [31:0] data;   // Zero for markers
   } stream_item_t;

endpackage

// File: src/yuv420_top.sv
`timescale 1ns/1ps

module yuv420_top #(
   parameter int INPUT_CREDITS = 4,
   parameter int MAX_COLS      = 64
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               yuv_en,
   input  logic               yuv420_en,
   input  logic               in_valid,
   input  stream_pkg::dtype_e in_dtype,
   input  logic [15:0]        in_meta,
   input  pixel_pkg::pix_t    in_y,
   input  pixel_pkg::pix_t    in_u,
   input  pixel_pkg::pix_t    in_v,
   output logic               in_credit,
   output logic               out_valid,
   output stream_pkg::dtype_e out_dtype,
   output logic [31:0]        out_data,
   input  logic               out_credit
);
   import pixel_pkg::*;

   pix_t avg_u;
   pix_t avg_v;
   logic dump;

   pixel_beat_if beat_if ();

   // Luma and chroma paths run side by side with equal latency
   luma_align u_luma_align (
      .clk      (clk),
      .resetb   (resetb),
      .yuv_en   (yuv_en),
      .in_valid (in_valid),
      .in_dtype (in_dtype),
      .in_y     (in_y),
      .in_u     (in_u),
      .in_v     (in_v),
      .in_meta  (in_meta),
      .beat     (beat_if.sender)
   );

   chroma_subsample #(
      .MAX_COLS (MAX_COLS)
   ) u_chroma_subsample (
      .clk      (clk),
      .resetb   (resetb),
      .yuv_en   (yuv_en),
      .in_valid (in_valid),
      .in_dtype (in_dtype),
      .in_u     (in_u),
      .in_v     (in_v),
      .avg_u    (avg_u),
      .avg_v    (avg_v),
      .dump     (dump)
   );

   stream_packer #(
      .INPUT_CREDITS (INPUT_CREDITS)
   ) u_stream_packer (
      .clk        (clk),
      .resetb     (resetb),
      .yuv420_en  (yuv420_en),
      .beat       (beat_if.receiver),
      .avg_u      (avg_u),
      .avg_v      (avg_v),
      .dump       (dump),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_dtype  (out_dtype),
      .out_data   (out_data),
      .out_credit (out_credit)
   );

endmodule
